// ==== rtl/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Fully associative, one line per way.
`define ICACHE_WAYS 4

// 32-bit words per line.
`define ICACHE_LINE_WORDS 4

`define ICACHE_WAY_BITS $clog2(`ICACHE_WAYS)
`define ICACHE_OFFSET_BITS $clog2(`ICACHE_LINE_WORDS)

// First fetch address after reset.
`define RESET_PC 32'h0000_0000

`endif

// ==== rtl/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

    // Word index bits and the byte position where the tag starts.
    localparam int OFFSET_W = `ICACHE_OFFSET_BITS;
    localparam int LINE_LSB = OFFSET_W + 2;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [32*`ICACHE_LINE_WORDS-1:0] line_t;
    typedef logic [31-LINE_LSB:0] tag_t;
    typedef logic [`ICACHE_WAY_BITS-1:0] way_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    typedef enum logic [1:0] {
        IF_RUN,    // One instruction per cycle.
        IF_MISS,   // Waiting for a line refill.
        IF_BRANCH  // Waiting for branch resolution.
    } fetch_state_e;

    // Opcodes that redirect control flow.
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    localparam word_t NOP = 32'h0000_0013; // addi x0, x0, 0.

endpackage : fetch_pkg

// ==== rtl/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top (
    input  logic             clk_i,
    input  logic             rst_n_i,

    // Core side.
    input  logic             stall_i,
    input  logic             branch_done_i,
    input  logic             branch_taken_i,
    input  fetch_pkg::addr_t branch_target_i,
    output fetch_pkg::word_t instr_o,
    output fetch_pkg::addr_t pc_o,
    output logic             instr_valid_o,

    // Memory side.
    output logic             mem_req_o,
    output fetch_pkg::addr_t mem_addr_o,
    input  logic             mem_valid_i,
    input  fetch_pkg::line_t mem_line_i
);

    import fetch_pkg::*;

    tag_t    lookup_tag;
    offset_t offset;
    logic    hit;
    way_t    hit_way;
    word_t   word;

    refill_if refill_bus ();

    icache_tag_array icache_tag_array_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .lookup_tag_i (lookup_tag),
        .fill         (refill_bus.array),
        .hit_o        (hit),
        .hit_way_o    (hit_way)
    );

    icache_data_array icache_data_array_inst (
        .clk_i    (clk_i),
        .way_i    (hit_way),
        .offset_i (offset),
        .fill     (refill_bus.array),
        .word_o   (word)
    );

    refill_unit refill_unit_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rf          (refill_bus.refill),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_valid_i (mem_valid_i),
        .mem_line_i  (mem_line_i)
    );

    if_stage if_stage_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_i),
        .branch_done_i   (branch_done_i),
        .branch_taken_i  (branch_taken_i),
        .branch_target_i (branch_target_i),
        .hit_i           (hit),
        .word_i          (word),
        .lookup_tag_o    (lookup_tag),
        .offset_o        (offset),
        .rf              (refill_bus.stage),
        .instr_o         (instr_o),
        .pc_o            (pc_o),
        .instr_valid_o   (instr_valid_o)
    );

endmodule : fetch_top

// ==== rtl/icache_data_array.sv ====
`timescale 1ns/1ns
`include "fetch_config.svh"

module icache_data_array (
    input  logic               clk_i,

    // Read side, driven by the tag match and the PC.
    input  fetch_pkg::way_t    way_i,
    input  fetch_pkg::offset_t offset_i,

    // Whole-line refill write.
    refill_if.array            fill,

    output fetch_pkg::word_t   word_o
);

    import fetch_pkg::*;

    line_t data_q [`ICACHE_WAYS];
    line_t rd_line;

    always_ff @(posedge clk_i) begin
        if (fill.fill) begin
            data_q[fill.fill_way] <= fill.fill_line;
        end
    end

    assign rd_line = data_q[way_i];

    // Word 0 sits in the low bits of the line.
    always_comb begin
        word_o = '0;
        for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
            if (offset_t'(w) == offset_i) begin
                word_o = rd_line[w*32 +: 32];
            end
        end
    end

endmodule : icache_data_array

// ==== rtl/icache_tag_array.sv ====
`timescale 1ns/1ns
`include "fetch_config.svh"

module icache_tag_array (
    input  logic             clk_i,
    input  logic             rst_n_i,

    // Lookup side.
    input  fetch_pkg::tag_t  lookup_tag_i,

    // Refill write side.
    refill_if.array          fill,

    output logic             hit_o,
    output fetch_pkg::way_t  hit_way_o
);

    import fetch_pkg::*;

    logic [`ICACHE_WAYS-1:0] valid_q;
    tag_t                    tag_q [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0] match;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill.fill) begin
            valid_q[fill.fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill.fill) begin
            tag_q[fill.fill_way] <= fill.fill_tag;
        end
    end

    // Parallel compare over all ways.
    always_comb begin
        for (int i = 0; i < `ICACHE_WAYS; i++) begin
            match[i] = valid_q[i] && (tag_q[i] == lookup_tag_i);
        end
    end

    // A tag lives in at most one way, so the encoder needs no priority.
    always_comb begin
        hit_o     = |match;
        hit_way_o = '0;
        for (int i = 0; i < `ICACHE_WAYS; i++) begin
            if (match[i]) begin
                hit_way_o = way_t'(i);
            end
        end
    end

endmodule : icache_tag_array

// ==== rtl/if_stage.sv ====
`timescale 1ns/1ns
`include "fetch_config.svh"

module if_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Core side control.
    input  logic               stall_i,
    input  logic               branch_done_i,
    input  logic               branch_taken_i,
    input  fetch_pkg::addr_t   branch_target_i,

    // Cache lookup.
    input  logic               hit_i,
    input  fetch_pkg::word_t   word_i,
    output fetch_pkg::tag_t    lookup_tag_o,
    output fetch_pkg::offset_t offset_o,

    refill_if.stage            rf,

    // Fetched instruction.
    output fetch_pkg::word_t   instr_o,
    output fetch_pkg::addr_t   pc_o,
    output logic               instr_valid_o
);

    import fetch_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;
    addr_t        pc_q;      // Fetch PC.
    addr_t        pc_d;
    logic         send;      // An instruction leaves this cycle.
    logic         is_branch;

    word_t        instr_q;
    addr_t        pc_out_q;
    logic         valid_q;

    assign lookup_tag_o = pc_q[31:LINE_LSB];
    assign offset_o     = pc_q[LINE_LSB-1:2];

    assign rf.miss     = (state_q == IF_MISS);
    assign rf.miss_tag = pc_q[31:LINE_LSB];

    assign is_branch = (word_i[6:0] == OPCODE_BRANCH) ||
                       (word_i[6:0] == OPCODE_JAL) ||
                       (word_i[6:0] == OPCODE_JALR);

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        send    = 1'b0;
        unique case (state_q)
            IF_RUN: begin
                if (!stall_i) begin
                    if (!hit_i) begin
                        state_d = IF_MISS; // Bubble, same PC again after the fill.
                    end else begin
                        send = 1'b1;
                        pc_d = pc_q + 32'd4;
                        if (is_branch) state_d = IF_BRANCH;
                    end
                end
            end
            IF_MISS: begin
                // A refill in flight completes even under stall.
                if (rf.fill) state_d = IF_RUN;
            end
            IF_BRANCH: begin
                if (branch_done_i) begin
                    state_d = IF_RUN;
                    // Not taken keeps PC+4 of the branch.
                    if (branch_taken_i) pc_d = branch_target_i;
                end
            end
            default: state_d = IF_RUN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IF_RUN;
            pc_q    <= `RESET_PC;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    // Output register, frozen while the core stalls.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            instr_q  <= NOP;
            pc_out_q <= `RESET_PC;
            valid_q  <= 1'b0;
        end else if (!stall_i) begin
            instr_q <= send ? word_i : NOP;
            valid_q <= send;
            if (send) pc_out_q <= pc_q; // Bubbles keep the last PC.
        end
    end

    assign instr_o       = instr_q;
    assign pc_o          = pc_out_q;
    assign instr_valid_o = valid_q;

endmodule : if_stage

// ==== rtl/refill_if.sv ====
`timescale 1ns/1ns

interface refill_if;
    import fetch_pkg::*;

    logic  miss;      // Level, held while the stage waits.
    tag_t  miss_tag;
    logic  fill;      // One-cycle write strobe.
    way_t  fill_way;
    tag_t  fill_tag;
    line_t fill_line;

    modport stage (output miss, output miss_tag, input fill);

    modport refill (
        input  miss, miss_tag,
        output fill, fill_way, fill_tag, fill_line
    );

    modport array (input fill, fill_way, fill_tag, fill_line);

endinterface : refill_if

// ==== rtl/refill_unit.sv ====
`timescale 1ns/1ns
`include "fetch_config.svh"

module refill_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,

    refill_if.refill          rf,

    // External memory, one line per request.
    output logic              mem_req_o,
    output fetch_pkg::addr_t  mem_addr_o,
    input  logic              mem_valid_i,
    input  fetch_pkg::line_t  mem_line_i
);

    import fetch_pkg::*;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_REQ,
        RF_WAIT
    } refill_state_e;

    refill_state_e state_q;
    tag_t          tag_q;
    line_t         line_q;
    way_t          victim_q;
    logic          fill_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= RF_IDLE;
            victim_q <= '0;
            fill_q   <= 1'b0;
        end else begin
            fill_q <= 1'b0;
            unique case (state_q)
                // Miss is still high during the fill cycle.
                RF_IDLE: if (rf.miss && !fill_q) state_q <= RF_REQ;
                RF_REQ:  state_q <= RF_WAIT;
                RF_WAIT: begin
                    if (mem_valid_i) begin
                        state_q <= RF_IDLE;
                        fill_q  <= 1'b1;
                    end
                end
                default: state_q <= RF_IDLE;
            endcase
            if (fill_q) begin // Round-robin victim.
                victim_q <= (victim_q == way_t'(`ICACHE_WAYS - 1)) ? '0 : victim_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RF_IDLE && rf.miss) tag_q <= rf.miss_tag;
        if (mem_valid_i) line_q <= mem_line_i;
    end

    assign mem_req_o  = (state_q == RF_REQ);
    assign mem_addr_o = {tag_q, {LINE_LSB{1'b0}}}; // Line aligned.

    assign rf.fill      = fill_q;
    assign rf.fill_way  = victim_q;
    assign rf.fill_tag  = tag_q;
    assign rf.fill_line = line_q;

endmodule : refill_unit

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module fetch_tb; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vfetch_tb)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" <<< "$output"; then
    exit 0
fi
exit 1

// ==== tb.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/refill_if.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/refill_unit.sv
rtl/if_stage.sv
rtl/fetch_top.sv
tests/fetch_sva.sv
tests/fetch_tb.sv

// ==== tests/fetch_sva.sv ====
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_sva (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             stall_i,
    input logic             miss_i,
    input logic             instr_valid_o,
    input fetch_pkg::addr_t pc_o,
    input logic             mem_req_o,
    input fetch_pkg::addr_t mem_addr_o,
    input logic             mem_valid_i
);

    logic outstanding_q; // Request sent, response not yet seen.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (mem_req_o) begin
            outstanding_q <= 1'b1;
        end else if (mem_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    single_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o |-> !outstanding_q) else $error("mem_req_o with a request outstanding");

    line_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o |-> (mem_addr_o % (4 * `ICACHE_LINE_WORDS)) == 0)
        else $error("mem_addr_o not line aligned");

    miss_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(miss_i) |-> !instr_valid_o) else $error("valid instruction on a miss");

    stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> $stable(pc_o)) else $error("pc_o moved under stall_i");

endmodule : fetch_sva

bind fetch_top fetch_sva fetch_sva_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .miss_i        (refill_bus.miss),
    .instr_valid_o (instr_valid_o),
    .pc_o          (pc_o),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_valid_i   (mem_valid_i)
);

// ==== tests/fetch_tb.sv ====
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int REC_WORDS = 512;
    localparam int MAX_CPI   = 40; // Refill, branch wait and stalls per pair.

    logic  clk_i;
    logic  rst_n_i;
    logic  stall_i;
    logic  branch_done_i;
    logic  branch_taken_i;
    addr_t branch_target_i;
    word_t instr_o;
    addr_t pc_o;
    logic  instr_valid_o;
    logic  mem_req_o;
    addr_t mem_addr_o;
    logic  mem_valid_i;
    line_t mem_line_i;

    logic [31:0] recs [REC_WORDS];
    word_t       mem [addr_t];                // Sparse memory image.
    addr_t       exp_pc [$];
    word_t       exp_instr [$];
    logic        out_taken [$];
    addr_t       out_target [$];
    addr_t       cached_line [`ICACHE_WAYS];  // Lines the cache should hold.
    logic        cached_ok [`ICACHE_WAYS];
    int          victim;
    int          matched;
    int          branch_wait;
    int          mem_wait;
    logic        branch_open;
    addr_t       req_addr;

    fetch_top fetch_top_inst (.*);

    function automatic word_t read_mem(addr_t a);
        if (mem.exists(a)) return mem[a];
        return {a[24:0] ^ a[31:7], 7'h13}; // OP-IMM filler.
    endfunction

    function automatic addr_t line_of(addr_t a);
        return a - a % (4 * `ICACHE_LINE_WORDS);
    endfunction

    function automatic logic in_cache(addr_t a);
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (cached_ok[w] && cached_line[w] == a) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic is_redirect(word_t w);
        return w[6:0] == OPCODE_BRANCH || w[6:0] == OPCODE_JAL || w[6:0] == OPCODE_JALR;
    endfunction

    task automatic stop_run(string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic compare_addr(string name, addr_t expected, addr_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic compare_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // Each record holds a kind and two fields.
    task automatic load_tests();
        int i;
        for (i = 0; i < REC_WORDS; i++) recs[i] = '0;
        $readmemh("tests/fetch_tests.txt", recs);
        i = 0;
        while (i + 2 < REC_WORDS && recs[i] != 0) begin
            case (recs[i])
                1: mem[recs[i + 1]] = recs[i + 2];
                2: begin
                    out_taken.push_back(recs[i + 1][0]);
                    out_target.push_back(recs[i + 2]);
                end
                3: begin
                    exp_pc.push_back(recs[i + 1]);
                    exp_instr.push_back(recs[i + 2]);
                end
                default: stop_run("Unknown record kind in tests/fetch_tests.txt.");
            endcase
            i += 3;
        end
        if (exp_pc.size() == 0) stop_run("No expected fetch pairs in tests/fetch_tests.txt.");
    endtask

    // Outputs change only at an edge where stall_i was low.
    task automatic check_output();
        if (stall_i) return;
        if (!instr_valid_o) begin
            compare_word($sformatf("bubble[%0d]", matched), NOP, instr_o);
            return;
        end
        if (branch_open) stop_run("Valid instruction sent before branch_done_i.");
        compare_addr($sformatf("pc[%0d]", matched), exp_pc[matched], pc_o);
        compare_word($sformatf("instr[%0d]", matched), exp_instr[matched], instr_o);
        compare_word($sformatf("image[%0d]", matched), read_mem(pc_o), instr_o);
        if (!in_cache(line_of(pc_o))) begin
            stop_run($sformatf("PC %h was sent without a refill of its line.", pc_o));
        end
        if (is_redirect(instr_o)) begin
            branch_open = 1'b1;
            branch_wait = 1 + $urandom % 4;
        end
        matched++;
    endtask

    task automatic serve_memory();
        mem_valid_i = 1'b0;
        if (mem_req_o) begin
            if (mem_wait != 0) stop_run("Second mem_req_o while a request is outstanding.");
            compare_addr($sformatf("mem_addr[%0d]", matched), line_of(exp_pc[matched]),
                         mem_addr_o);
            if (in_cache(mem_addr_o)) stop_run("Request for a line that is still cached.");
            req_addr = mem_addr_o;
            mem_wait = 1 + $urandom % 6;
        end else if (mem_wait != 0) begin
            mem_wait--;
            if (mem_wait == 0) begin
                for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
                    mem_line_i[w * 32 +: 32] = read_mem(req_addr + addr_t'(w * 4));
                end
                mem_valid_i         = 1'b1;
                cached_line[victim] = req_addr; // Round-robin victim.
                cached_ok[victim]   = 1'b1;
                victim              = (victim + 1) % `ICACHE_WAYS;
            end
        end
    endtask

    task automatic resolve_branch();
        if (branch_done_i) branch_open = 1'b0; // Pulse taken at the last edge.
        branch_done_i = 1'b0;
        if (branch_wait == 0) return;
        branch_wait--;
        if (branch_wait != 0) return;
        if (out_taken.size() == 0) stop_run("More branches fetched than outcomes in the file.");
        branch_taken_i  = out_taken.pop_front();
        branch_target_i = out_target.pop_front();
        branch_done_i   = 1'b1;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        void'($urandom(47446));
        rst_n_i         = 1'b0;
        stall_i         = 1'b0;
        branch_done_i   = 1'b0;
        branch_taken_i  = 1'b0;
        branch_target_i = '0;
        mem_valid_i     = 1'b0;
        mem_line_i      = '0;
        victim          = 0;
        matched         = 0;
        branch_wait     = 0;
        mem_wait        = 0;
        branch_open     = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) cached_ok[w] = 1'b0;
        load_tests();
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        while (matched < exp_pc.size()) begin
            @(negedge clk_i);
            check_output();
            if (matched < exp_pc.size()) begin
                serve_memory();
                resolve_branch();
                stall_i = ($urandom % 4) == 0;
            end
        end
        $display("TB PASSED");
        $finish;
    end

    // Watchdog.
    initial begin
        #1;
        repeat (8 + MAX_CPI * exp_pc.size()) @(posedge clk_i);
        stop_run($sformatf("Timeout with %0d of %0d fetch pairs seen.", matched, exp_pc.size()));
    end

endmodule : fetch_tb

// ==== tests/fetch_tests.txt ====
// Records of three hex words: kind, field a, field b.
// Kind 1 memory word (address, data), 2 branch outcome (taken, target), 3 fetch (pc, instr).
// Program image over five lines.
1 00000000 00100093  1 00000004 00200113
1 00000008 00308193  1 0000000c 00208863
1 00000010 00110113  1 00000014 00418193
1 00000018 fe2094e3  1 0000001c 0040006f
1 00000020 00000297  1 00000024 00c0006f
1 00000030 02028293  1 00000034 00000013
1 00000038 00028067  1 00000040 00500313
1 00000044 fbdff06f
// Branch outcomes in program order.
2 0 00000000  2 1 00000000
2 0 00000000  2 0 00000000
2 1 00000020  2 1 00000030
2 1 00000040  2 1 00000000
// First pass over lines 0 and 1.
3 00000000 00100093  3 00000004 00200113  3 00000008 00308193
3 0000000c 00208863  3 00000010 00110113  3 00000014 00418193
3 00000018 fe2094e3
// Second pass, all hits.
3 00000000 00100093  3 00000004 00200113  3 00000008 00308193
3 0000000c 00208863  3 00000010 00110113  3 00000014 00418193
3 00000018 fe2094e3  3 0000001c 0040006f
// Lines 2, 3 and 4, the last one evicts line 0.
3 00000020 00000297  3 00000024 00c0006f
3 00000030 02028293  3 00000034 00000013  3 00000038 00028067
3 00000040 00500313  3 00000044 fbdff06f
// Line 0 again, refetched from memory.
3 00000000 00100093  3 00000004 00200113  3 00000008 00308193
